/* logic/xoodyak_config.svh */
`ifndef XOODYAK_CONFIG_SVH
`define XOODYAK_CONFIG_SVH

// --------------------------------------------------
// Permutation schedule
// --------------------------------------------------
`define XOO_ROUNDS              12
`define XOO_ROUNDS_PER_CLK      3
`define XOO_PERM_CLOCKS         4

// --------------------------------------------------
// Cyclist domain and padding bytes
// --------------------------------------------------
`define CD_INIT                 8'h02
`define CD_ABSORB               8'h03
`define CU_CRYPT                8'h80
`define CU_SQUEEZE              8'h40
`define PAD_BYTE                8'h01

`endif

/* logic/xoodyak_pkg.sv */
package xoodyak_pkg;

        // Full Xoodoo state, byte i at bits 8i+7:8i
        typedef logic [383:0] state_t;

        // One plane, plane y sits at bit 128y of the state
        typedef logic [127:0] plane_t;

        // One lane, lane x sits at bit 32x of a plane
        typedef logic [31:0] lane_t;

        // Plaintext in, ciphertext or tag out
        typedef logic [191:0] text_t;
        typedef logic [351:0] ad_t;
        typedef logic [127:0] key_t;

        // Clock index inside one permutation
        typedef logic [1:0] step_t;

        // Operation codes match the opmode encoding
        typedef enum logic [2:0] {
                OP_IDLE    = 3'd0,
                OP_INIT    = 3'd1,
                OP_NONCE   = 3'd2,
                OP_ASSOC   = 3'd3,
                OP_CRYPT   = 3'd4,
                OP_SQUEEZE = 3'd6
        } op_t;

endpackage

/* logic/xoodoo_round.sv */
`timescale 1ns/100ps

module xoodoo_round (
        input  xoodyak_pkg::lane_t  rc,
        input  xoodyak_pkg::state_t round_in,
        output xoodyak_pkg::state_t round_out
);
        import xoodyak_pkg::*;

        // Cyclic plane shift, lane moves dx in x and rotates dz in z
        function automatic plane_t shift_plane(input plane_t p, input int dx, input int dz);
                plane_t      r;
                lane_t       l;
                logic [63:0] d;
                for (int x = 0; x < 4; x++) begin
                        l = p[32 * ((x + 4 - dx) % 4) +: 32];
                        d = {l, l} << dz;
                        r[32 * x +: 32] = d[63:32];
                end
                return r;
        endfunction

        plane_t a0, a1, a2;
        plane_t p, e;
        plane_t t0, t1, t2;
        plane_t w0, w1, w2;
        plane_t c0, c1, c2;

        // Split into planes
        assign a0 = round_in[0 +: 128];
        assign a1 = round_in[128 +: 128];
        assign a2 = round_in[256 +: 128];

        // --------------------------------------------------
        // Theta, column parity folded back into every plane
        // --------------------------------------------------
        assign p  = a0 ^ a1 ^ a2;
        assign e  = shift_plane(p, 1, 5) ^ shift_plane(p, 1, 14);
        assign t0 = a0 ^ e;
        assign t1 = a1 ^ e;
        assign t2 = a2 ^ e;

        // Rho-west, then iota on lane 0 of plane 0
        assign w0 = t0 ^ {96'b0, rc};
        assign w1 = shift_plane(t1, 1, 0);
        assign w2 = shift_plane(t2, 0, 11);

        // Chi, the only nonlinear step
        assign c0 = w0 ^ (~w1 & w2);
        assign c1 = w1 ^ (~w2 & w0);
        assign c2 = w2 ^ (~w0 & w1);

        // Rho-east, plane 0 passes straight through
        assign round_out = {shift_plane(c2, 2, 8), shift_plane(c1, 0, 1), c0};

endmodule

/* logic/xoodoo_perm.sv */
`timescale 1ns/100ps
`include "xoodyak_config.svh"

module xoodoo_perm (
        input  logic                eph1,
        input  logic                rst_n,
        input  xoodyak_pkg::op_t    phase,
        input  xoodyak_pkg::step_t  step,
        input  xoodyak_pkg::state_t perm_in,
        output xoodyak_pkg::state_t perm_out
);
        import xoodyak_pkg::*;

        // Round constants in specification order, LSB at z = 0
        localparam lane_t RC [`XOO_ROUNDS] = '{
                32'h058, 32'h038, 32'h3C0, 32'h0D0, 32'h120, 32'h014,
                32'h060, 32'h02C, 32'h380, 32'h0F0, 32'h1A0, 32'h012
        };

        state_t     chain [`XOO_ROUNDS_PER_CLK + 1];
        state_t     perm_q;
        logic [3:0] rc_base;

        // First round of this clock
        assign rc_base = 4'(step) * 4'(`XOO_ROUNDS_PER_CLK);

        // Fresh state at step 0, recirculate afterwards
        assign chain[0] = (step == '0) ? perm_in : perm_q;

        // --------------------------------------------------
        // Three rounds per clock
        // --------------------------------------------------
        for (genvar r = 0; r < `XOO_ROUNDS_PER_CLK; r++) begin : g_round
                xoodoo_round round_i (
                        .rc        (RC[rc_base + 4'(r)]),
                        .round_in  (chain[r]),
                        .round_out (chain[r + 1])
                );
        end

        // Intermediate state, wiped on reset
        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        perm_q <= '0;
                end else if (phase != OP_IDLE) begin
                        perm_q <= chain[`XOO_ROUNDS_PER_CLK];
                end
        end

        // Full result is valid during step 3
        assign perm_out = chain[`XOO_ROUNDS_PER_CLK];

endmodule

/* logic/cyclist_fsm.sv */
`timescale 1ns/100ps
`include "xoodyak_config.svh"

module cyclist_fsm (
        input  logic               eph1,
        input  logic               rst_n,
        input  logic [2:0]         opmode,
        output xoodyak_pkg::op_t   phase,
        output xoodyak_pkg::step_t step,
        output logic               state_we,
        output xoodyak_pkg::op_t   last_op,
        output logic               finished
);
        import xoodyak_pkg::*;

        op_t  cmd;
        logic last_step;

        // --------------------------------------------------
        // Command decode, decrypt and ratchet fall to idle
        // --------------------------------------------------
        always_comb begin
                case (opmode)
                        3'd1:    cmd = OP_INIT;
                        3'd2:    cmd = OP_NONCE;
                        3'd3:    cmd = OP_ASSOC;
                        3'd4:    cmd = OP_CRYPT;
                        3'd6:    cmd = OP_SQUEEZE;
                        default: cmd = OP_IDLE;
                endcase
        end

        // Final clock of a permutation
        assign last_step = (step == step_t'(`XOO_PERM_CLOCKS - 1));

        // Init has no permutation and commits at once
        assign state_we = (phase == OP_INIT) || ((phase != OP_IDLE) && last_step);

        // --------------------------------------------------
        // Phase, step counter and completed-operation record
        // --------------------------------------------------
        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        phase   <= OP_IDLE;
                        step    <= '0;
                        last_op <= OP_IDLE;
                end else if (phase == OP_IDLE) begin
                        // Command is a level, sampled only here
                        phase <= cmd;
                        step  <= '0;
                end else if (state_we) begin
                        phase   <= OP_IDLE;
                        step    <= '0;
                        last_op <= phase;
                end else begin
                        step <= step + 1'b1;
                end
        end

        // Level output, high whenever a new command can be taken
        assign finished = (phase == OP_IDLE);

endmodule

/* logic/cyclist_state.sv */
`timescale 1ns/100ps
`include "xoodyak_config.svh"

module cyclist_state (
        input  logic                eph1,
        input  logic                rst_n,
        input  xoodyak_pkg::op_t    phase,
        input  logic                state_we,
        input  xoodyak_pkg::op_t    last_op,
        input  xoodyak_pkg::text_t  textin,
        input  xoodyak_pkg::key_t   nonce,
        input  xoodyak_pkg::ad_t    assodata,
        input  xoodyak_pkg::key_t   key,
        input  xoodyak_pkg::state_t perm_out,
        output xoodyak_pkg::state_t perm_in,
        output xoodyak_pkg::text_t  textout
);
        import xoodyak_pkg::*;

        text_t      text_r;
        key_t       nonce_r;
        ad_t        ad_r;
        key_t       key_r;
        state_t     saved_q;
        state_t     down_state;
        logic [7:0] up_byte;

        // Inputs follow the pins until a command starts
        always_ff @(posedge eph1) begin
                if (phase == OP_IDLE) begin
                        text_r  <= textin;
                        nonce_r <= nonce;
                        ad_r    <= assodata;
                        key_r   <= key;
                end
        end

        // --------------------------------------------------
        // Up adds the domain byte into byte 47 before permuting
        // --------------------------------------------------
        always_comb begin
                case (phase)
                        OP_CRYPT:   up_byte = `CU_CRYPT;
                        OP_SQUEEZE: up_byte = `CU_SQUEEZE;
                        default:    up_byte = 8'h00;
                endcase
        end

        assign perm_in = saved_q ^ {up_byte, 376'b0};

        // --------------------------------------------------
        // Down absorbs into the permuted state
        // --------------------------------------------------
        always_comb begin
                down_state = perm_out;
                case (phase)
                        OP_INIT: begin
                                // Key, empty id, pad, then init domain
                                down_state             = '0;
                                down_state[127:0]      = key_r;
                                down_state[8*17 +: 8]  = `PAD_BYTE;
                                down_state[8*47 +: 8]  = `CD_INIT;
                        end
                        OP_NONCE: begin
                                down_state[127:0]     ^= nonce_r;
                                down_state[8*16 +: 8] ^= `PAD_BYTE;
                                down_state[8*47 +: 8] ^= `CD_ABSORB;
                        end
                        OP_ASSOC: begin
                                down_state[351:0]     ^= ad_r;
                                down_state[8*44 +: 8] ^= `PAD_BYTE;
                                down_state[8*47 +: 8] ^= `CD_ABSORB;
                        end
                        OP_CRYPT: begin
                                // Low 24 bytes become the ciphertext
                                down_state[191:0]     ^= text_r;
                                down_state[8*24 +: 8] ^= `PAD_BYTE;
                        end
                        default: down_state = perm_out;
                endcase
        end

        // Saved cyclist state
        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        saved_q <= '0;
                end else if (state_we) begin
                        saved_q <= down_state;
                end
        end

        // Output view of the saved state, chosen by the last operation
        always_comb begin
                case (last_op)
                        OP_CRYPT:   textout = saved_q[191:0];
                        OP_SQUEEZE: textout = {64'b0, saved_q[127:0]};
                        default:    textout = '0;
                endcase
        end

endmodule

/* logic/xoodyak_top.sv */
`timescale 1ns/100ps

module xoodyak_top (
        input  logic               eph1,
        input  logic               rst_n,
        input  logic [2:0]         opmode,
        input  xoodyak_pkg::text_t textin,
        input  xoodyak_pkg::key_t  nonce,
        input  xoodyak_pkg::ad_t   assodata,
        input  xoodyak_pkg::key_t  key,
        output xoodyak_pkg::text_t textout,
        output logic               finished
);
        import xoodyak_pkg::*;

        op_t    phase;
        op_t    last_op;
        step_t  step;
        logic   state_we;
        state_t perm_in;
        state_t perm_out;

        // Sequencer
        cyclist_fsm fsm_i (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .opmode   (opmode),
                .phase    (phase),
                .step     (step),
                .state_we (state_we),
                .last_op  (last_op),
                .finished (finished)
        );

        // Twelve rounds over four clocks
        xoodoo_perm perm_i (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .phase    (phase),
                .step     (step),
                .perm_in  (perm_in),
                .perm_out (perm_out)
        );

        // Up and Down around the permutation
        cyclist_state state_i (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .phase    (phase),
                .state_we (state_we),
                .last_op  (last_op),
                .textin   (textin),
                .nonce    (nonce),
                .assodata (assodata),
                .key      (key),
                .perm_out (perm_out),
                .perm_in  (perm_in),
                .textout  (textout)
        );

endmodule

/* test/xoodoo_ref.svh */
`ifndef XOODOO_REF_SVH
`define XOODOO_REF_SVH

// --------------------------------------------------
// Xoodoo reference model with lanes held as a[x][y]
// --------------------------------------------------

// Cyclic left rotation of one lane by a nonzero amount
function automatic lane_t rotl_lane(input lane_t v, input int n);
        return (v << n) | (v >> (32 - n));
endfunction

// One round straight from the specification steps
function automatic state_t round_model(input state_t s, input lane_t rc);
        lane_t  p [4];
        lane_t  a [4][3];
        lane_t  b [4][3];
        lane_t  e;
        state_t r;
        // Column parity
        for (int x = 0; x < 4; x++) begin
                p[x] = s[32 * x +: 32] ^ s[128 + 32 * x +: 32] ^ s[256 + 32 * x +: 32];
        end
        // Theta effect comes from column x-1
        for (int x = 0; x < 4; x++) begin
                e = rotl_lane(p[(x + 3) % 4], 5) ^ rotl_lane(p[(x + 3) % 4], 14);
                for (int y = 0; y < 3; y++) begin
                        a[x][y] = s[128 * y + 32 * x +: 32] ^ e;
                end
        end
        // Rho-west, then iota on lane (0, 0)
        for (int x = 0; x < 4; x++) begin
                b[x][0] = a[x][0];
                b[x][1] = a[(x + 3) % 4][1];
                b[x][2] = rotl_lane(a[x][2], 11);
        end
        b[0][0] ^= rc;
        // Chi per column
        for (int x = 0; x < 4; x++) begin
                for (int y = 0; y < 3; y++) begin
                        a[x][y] = b[x][y] ^ (~b[x][(y + 1) % 3] & b[x][(y + 2) % 3]);
                end
        end
        // Rho-east moves plane 2 by two columns
        for (int x = 0; x < 4; x++) begin
                r[32 * x +: 32]       = a[x][0];
                r[128 + 32 * x +: 32] = rotl_lane(a[x][1], 1);
                r[256 + 32 * x +: 32] = rotl_lane(a[(x + 2) % 4][2], 8);
        end
        return r;
endfunction

// Full twelve rounds
function automatic state_t perm_model(input state_t s);
        lane_t  rc [12];
        state_t t;
        rc = '{32'h058, 32'h038, 32'h3C0, 32'h0D0, 32'h120, 32'h014,
               32'h060, 32'h02C, 32'h380, 32'h0F0, 32'h1A0, 32'h012};
        t = s;
        for (int i = 0; i < 12; i++) begin
                t = round_model(t, rc[i]);
        end
        return t;
endfunction

// --------------------------------------------------
// Cyclist rules
// --------------------------------------------------

// Key in bytes 0..15, pad at 17, init domain at 47
function automatic state_t init_state(input key_t k);
        return {8'h02, 232'b0, 8'h01, 8'h00, k};
endfunction

// Up byte cu, permute, then len data bytes, pad and domain byte cd
function automatic state_t up_down(input state_t s, input logic [7:0] cu,
                                   input ad_t data, input int len,
                                   input logic [7:0] cd);
        state_t t;
        t = s;
        t[8 * 47 +: 8] ^= cu;
        t = perm_model(t);
        for (int i = 0; i < len; i++) begin
                t[8 * i +: 8] ^= data[8 * i +: 8];
        end
        // Squeeze passes len 0 and gets no pad
        if (len > 0) begin
                t[8 * len +: 8] ^= 8'h01;
        end
        t[8 * 47 +: 8] ^= cd;
        return t;
endfunction

`endif

/* test/xoodyak_tb.sv */
`timescale 1ns/100ps

module xoodyak_tb;
        import xoodyak_pkg::*;

        localparam int CLK_PERIOD     = 20;
        localparam int RESET_CYCLES   = 3;
        localparam int DRIVE_DELAY    = 2;
        localparam int TIMEOUT_CYCLES = 40;
        localparam int SEED           = 43612;

        logic       eph1;
        logic       rst_n;
        logic [2:0] opmode;
        text_t      textin;
        key_t       nonce;
        ad_t        assodata;
        key_t       key;
        text_t      textout;
        logic       finished;
        logic       valid_op;

        // Expected cyclist state and error bookkeeping
        state_t model_s;
        text_t  plain;
        int     checks;
        int     errors;
        int     seen_errors;
        int     prop_errors = 0;

        `include "xoodoo_ref.svh"

        xoodyak_top dut_i (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .opmode   (opmode),
                .textin   (textin),
                .nonce    (nonce),
                .assodata (assodata),
                .key      (key),
                .textout  (textout),
                .finished (finished)
        );

        always #(CLK_PERIOD / 2) eph1 = ~eph1;

        // Opcodes that start an operation
        assign valid_op = opmode inside {3'd1, 3'd2, 3'd3, 3'd4, 3'd6};

        // Finished drops one edge after an accepted opcode and stays high for any other
        assert property (@(posedge eph1) disable iff (!rst_n)
                finished |=> (finished == !$past(valid_op)))
        else begin
                prop_errors++;
                $display("[ERROR] %0t ns finished: got %b, expected %b",
                         $time, $sampled(finished), !$sampled(finished));
        end

        // --------------------------------------------------
        // Helpers
        // --------------------------------------------------
        task automatic next_cycle();
                @(posedge eph1);
                #(DRIVE_DELAY);
        endtask

        task automatic check_eq(input string name, input logic [191:0] got,
                                input logic [191:0] want);
                checks++;
                assert (got === want) else begin
                        errors++;
                        $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, want);
                end
        endtask

        task automatic randomize_data();
                for (int i = 0; i < 11; i++) begin
                        assodata[32 * i +: 32] = $urandom;
                        if (i < 6) begin
                                textin[32 * i +: 32] = $urandom;
                        end
                        if (i < 4) begin
                                nonce[32 * i +: 32] = $urandom;
                                key[32 * i +: 32]   = $urandom;
                        end
                end
        endtask

        // Issue one command, count the cycles finished stays low
        task automatic run_cmd(input logic [2:0] op, input int want_cycles, input bit scramble);
                int cycles;
                cycles = 0;
                opmode = op;
                next_cycle();
                while (!finished && cycles < TIMEOUT_CYCLES) begin
                        // Pin changes while busy must not matter
                        opmode = scramble ? 3'($urandom) : 3'd0;
                        if (scramble) begin
                                randomize_data();
                        end
                        cycles++;
                        next_cycle();
                end
                opmode = 3'd0;
                if (!finished) begin
                        errors++;
                        $display("Timeout, finished still low after %0d cycles", cycles);
                end
                check_eq("finished low cycles", 192'(cycles), 192'(want_cycles));
        endtask

        task automatic end_test(input string name);
                if (errors + prop_errors == seen_errors) begin
                        $display("%s: ok", name);
                end else begin
                        $display("%s: %0d errors", name, errors + prop_errors - seen_errors);
                end
                seen_errors = errors + prop_errors;
        endtask

        // --------------------------------------------------
        // Stimulus
        // --------------------------------------------------
        initial begin
                eph1        = 1'b0;
                rst_n       = 1'b0;
                opmode      = 3'd0;
                textin      = '0;
                nonce       = '0;
                assodata    = '0;
                key         = '0;
                checks      = 0;
                errors      = 0;
                seen_errors = 0;
                void'($urandom(SEED));
                repeat (RESET_CYCLES) @(posedge eph1);
                #(DRIVE_DELAY);
                rst_n = 1'b1;

                check_eq("finished", 192'(finished), 192'd1);
                check_eq("textout", textout, '0);
                end_test("reset state");

                // Init, nonce and assoc latencies with textout held at zero
                randomize_data();
                run_cmd(3'd1, 1, 1'b0);
                model_s = init_state(key);
                check_eq("textout", textout, '0);
                run_cmd(3'd2, 4, 1'b0);
                model_s = up_down(model_s, 8'h00, ad_t'(nonce), 16, 8'h03);
                check_eq("textout", textout, '0);
                run_cmd(3'd3, 4, 1'b0);
                model_s = up_down(model_s, 8'h00, assodata, 44, 8'h03);
                check_eq("textout", textout, '0);
                end_test("command latency");

                randomize_data();
                run_cmd(3'd4, 4, 1'b0);
                model_s = up_down(model_s, 8'h80, ad_t'(textin), 24, 8'h00);
                check_eq("textout", textout, model_s[191:0]);
                end_test("encryption");

                // Tag followed by a fresh nonce that clears the output view
                run_cmd(3'd6, 4, 1'b0);
                model_s = up_down(model_s, 8'h40, '0, 0, 8'h00);
                check_eq("textout", textout, {64'b0, model_s[127:0]});
                randomize_data();
                run_cmd(3'd2, 4, 1'b0);
                model_s = up_down(model_s, 8'h00, ad_t'(nonce), 16, 8'h03);
                check_eq("textout", textout, '0);
                end_test("tag");

                // Decrypt and ratchet opcodes are no-ops
                opmode = 3'd5;
                next_cycle();
                check_eq("finished", 192'(finished), 192'd1);
                opmode = 3'd7;
                next_cycle();
                check_eq("finished", 192'(finished), 192'd1);
                randomize_data();
                plain = textin;
                run_cmd(3'd4, 4, 1'b1);
                model_s = up_down(model_s, 8'h80, ad_t'(plain), 24, 8'h00);
                check_eq("textout", textout, model_s[191:0]);
                run_cmd(3'd6, 4, 1'b1);
                model_s = up_down(model_s, 8'h40, '0, 0, 8'h00);
                check_eq("textout", textout, {64'b0, model_s[127:0]});
                end_test("ignored inputs");

                $display("Checks: %0d, errors: %0d", checks, errors + prop_errors);
                if (errors + prop_errors == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

/* sim.f */
+incdir+logic
+incdir+test
logic/xoodyak_pkg.sv
logic/xoodoo_round.sv
logic/xoodoo_perm.sv
logic/cyclist_fsm.sv
logic/cyclist_state.sv
logic/xoodyak_top.sv
test/xoodyak_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = xoodyak_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
